// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_stepctl
FILELIST  ?= stepctl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/stepctl_cmd_pkg.sv
`default_nettype none

package stepctl_cmd_pkg;

  // SPI transfer unit, one word per CS frame
  localparam int WORD_W = 64;

  // Header layout, code byte on top
  localparam int CODE_W = 8;
  localparam int ARG_W  = WORD_W - CODE_W;

  // Header codes
  localparam logic [CODE_W-1:0] CMD_MOVE      = 8'h01;  // Coordinated move, arg[0] is dir
  localparam logic [CODE_W-1:0] CMD_DIVISOR   = 8'h03;  // Tick divisor in arg[23:0]
  localparam logic [CODE_W-1:0] CMD_MICROSTEP = 8'h04;  // Microstep mode in arg[2:0]

  // Words after a move header
  // 1: duration in ticks
  // 2: initial rate, signed
  // 3: rate change per tick, signed
  localparam int MOVE_DATA_WORDS = 3;

  // One received word, seen as a header while idle
  // or as raw data while a message is being collected
  typedef union packed {
    struct packed {
      logic [CODE_W-1:0] code;  // Command byte, MSB first on the wire
      logic [ARG_W-1:0]  arg;   // Command argument
    } hdr;
    logic [WORD_W-1:0] data;    // Whole word as a value
  } spi_word_u;

endpackage

`default_nettype wire

// File: common/stepctl_motion_pkg.sv
`default_nettype none

package stepctl_motion_pkg;

  localparam int ACC_W = 64;  // Accumulator, rate and count width
  localparam int DIV_W = 24;  // Tick divisor width
  localparam int MS_W  = 3;   // Microstep mode field

  // Accumulator level worth one step, 2^40
  localparam logic signed [ACC_W-1:0] STEP_THRESHOLD = 64'sh0000_0100_0000_0000;

  // Divisor out of reset
  localparam logic [DIV_W-1:0] DIV_RESET = 24'd40;

  // Microstep modes, other codes ignored
  localparam logic [MS_W-1:0] MS_FULL = 3'd0;  // Index moves by 2
  localparam logic [MS_W-1:0] MS_HALF = 3'd1;  // Index moves by 1

  // Half-step drive table, bits are {a1, a2, b1, b2}
  // Even entries single coil, odd entries two coils
  localparam logic [7:0][3:0] PHASE_TABLE = {
    4'b1001,  // 7: A+ B-
    4'b0001,  // 6: B-
    4'b0101,  // 5: A- B-
    4'b0100,  // 4: A-
    4'b0110,  // 3: A- B+
    4'b0010,  // 2: B+
    4'b1010,  // 1: A+ B+
    4'b1000   // 0: A+
  };

endpackage

`default_nettype wire

// File: motion/move_profile.sv
`default_nettype none

module move_profile (
  input  logic                                        CLK,
  input  logic                                        rst,
  input  logic                                        move_start,
  input  logic [stepctl_motion_pkg::DIV_W-1:0]        divisor,
  input  logic [stepctl_motion_pkg::ACC_W-1:0]        duration,
  input  logic signed [stepctl_motion_pkg::ACC_W-1:0] rate_init,
  input  logic signed [stepctl_motion_pkg::ACC_W-1:0] rate_step,
  output logic                                        step_pulse,
  output logic                                        busy,
  output logic [stepctl_motion_pkg::ACC_W-1:0]        steps_done
);

  logic [stepctl_motion_pkg::DIV_W-1:0]        div_cnt;      // Clocks within tick
  logic [stepctl_motion_pkg::DIV_W-1:0]        div_next;
  logic [stepctl_motion_pkg::ACC_W-1:0]        tick_cnt;     // Ticks so far
  logic [stepctl_motion_pkg::ACC_W-1:0]        dur_q;        // Held for whole move
  logic [stepctl_motion_pkg::ACC_W-1:0]        step_cnt;     // Steps of running move
  logic signed [stepctl_motion_pkg::ACC_W-1:0] rate;         // Current substeps per tick
  logic signed [stepctl_motion_pkg::ACC_W-1:0] rate_step_q;
  logic signed [stepctl_motion_pkg::ACC_W-1:0] acc;          // Substep accumulator
  logic signed [stepctl_motion_pkg::ACC_W-1:0] acc_sum;
  logic                                        done;
  logic                                        tick;
  logic                                        step_now;

  assign div_next = div_cnt + 1'b1;
  assign done     = busy && (tick_cnt == dur_q);  // All ticks spent
  assign tick     = busy && !done && (div_next >= divisor);
  assign acc_sum  = acc + rate;
  assign step_now = (acc_sum >= stepctl_motion_pkg::STEP_THRESHOLD);  // Signed compare

  always_ff @(posedge CLK) begin
    if (rst) begin
      busy       <= 1'b0;
      step_pulse <= 1'b0;
      steps_done <= '0;
      div_cnt    <= '0;
      tick_cnt   <= '0;
      step_cnt   <= '0;
    end else begin
      step_pulse <= 1'b0;
      if (move_start) begin
        // Restart, any running count is lost
        busy     <= 1'b1;
        div_cnt  <= '0;
        tick_cnt <= '0;
        step_cnt <= '0;
      end else if (done) begin
        busy       <= 1'b0;
        steps_done <= step_cnt;  // Published for readback
      end else if (tick) begin
        div_cnt  <= '0;
        tick_cnt <= tick_cnt + 1'b1;
        if (step_now) begin
          step_cnt   <= step_cnt + 1'b1;
          step_pulse <= 1'b1;  // At most one per tick
        end
      end else if (busy) begin
        div_cnt <= div_next;
      end
    end
  end

  // Rate and substep arithmetic
  always_ff @(posedge CLK) begin
    if (move_start) begin
      acc         <= '0;
      rate        <= rate_init;
      dur_q       <= duration;
      rate_step_q <= rate_step;
    end else if (tick) begin
      if (step_now) begin
        acc <= acc_sum - stepctl_motion_pkg::STEP_THRESHOLD;
      end else begin
        acc <= acc_sum;
      end
      rate <= rate + rate_step_q;  // Rate changes after the add
    end
  end

endmodule

`default_nettype wire

// File: spi/spi_word_rx.sv
`default_nettype none

module spi_word_rx (
  input  logic                               CLK,
  input  logic                               rst,
  input  logic                               SCK,
  input  logic                               CS,
  input  logic                               COPI,
  input  logic [stepctl_cmd_pkg::WORD_W-1:0] reply_word,
  output logic                               CIPO,
  output logic                               word_valid,
  output stepctl_cmd_pkg::spi_word_u         word_data
);

  logic [2:0] sck_sync;   // Two sync stages, third for edge detect
  logic [2:0] cs_sync;
  logic [1:0] copi_sync;  // Kept in step with SCK stages
  logic       sck_rise;
  logic       cs_rise;
  logic       cs_fall;
  logic       frame_full;
  logic [6:0] bit_cnt;    // Bits in current frame, saturates
  logic [stepctl_cmd_pkg::WORD_W-1:0] rx_shift;
  logic [stepctl_cmd_pkg::WORD_W-1:0] tx_shift;

  assign sck_rise   = sck_sync[1] & ~sck_sync[2];
  assign cs_rise    = cs_sync[1] & ~cs_sync[2];  // End of frame
  assign cs_fall    = ~cs_sync[1] & cs_sync[2];  // Start of frame
  assign frame_full = (bit_cnt == 7'(stepctl_cmd_pkg::WORD_W));
  assign CIPO       = tx_shift[stepctl_cmd_pkg::WORD_W-1];  // MSB first

  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_sync   <= '0;
      cs_sync    <= '1;  // Deselected
      copi_sync  <= '0;
      bit_cnt    <= '0;
      tx_shift   <= '0;
      word_valid <= 1'b0;
    end else begin
      sck_sync   <= {sck_sync[1:0], SCK};
      cs_sync    <= {cs_sync[1:0], CS};
      copi_sync  <= {copi_sync[0], COPI};
      word_valid <= cs_rise & frame_full;  // Short or long frames dropped
      if (cs_fall) begin
        bit_cnt  <= '0;
        tx_shift <= reply_word;  // Reply latched for this frame
      end else if (sck_rise && !cs_sync[1]) begin
        tx_shift <= {tx_shift[stepctl_cmd_pkg::WORD_W-2:0], 1'b0};  // Next bit up
        if (bit_cnt != 7'h7f) begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // Receive shifter and word hold
  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_sync[1]) begin
      rx_shift <= {rx_shift[stepctl_cmd_pkg::WORD_W-2:0], copi_sync[1]};
    end
    if (cs_rise) begin
      word_data.data <= rx_shift;  // Stable until next frame ends
    end
  end

endmodule

`default_nettype wire

// File: src/cmd_decoder.sv
`default_nettype none

module cmd_decoder (
  input  logic                                     CLK,
  input  logic                                     rst,
  input  logic                                     word_valid,
  input  stepctl_cmd_pkg::spi_word_u               word_data,
  input  logic [stepctl_motion_pkg::ACC_W-1:0]     steps_done,
  output logic                                     dir,
  output logic [stepctl_motion_pkg::DIV_W-1:0]     divisor,
  output logic [stepctl_motion_pkg::MS_W-1:0]      ms_mode,
  output logic [stepctl_motion_pkg::ACC_W-1:0]     duration,
  output logic signed [stepctl_motion_pkg::ACC_W-1:0] rate_init,
  output logic signed [stepctl_motion_pkg::ACC_W-1:0] rate_step,
  output logic                                     move_start,
  output logic [stepctl_cmd_pkg::WORD_W-1:0]       reply_word,
  output logic                                     led
);

  logic       collecting;  // Header seen, data words pending
  logic [1:0] word_cnt;    // Data word index within move
  logic       last_word;
  logic [stepctl_motion_pkg::MS_W-1:0] mode_arg;

  assign last_word = (word_cnt == 2'(stepctl_cmd_pkg::MOVE_DATA_WORDS - 1));
  assign mode_arg  = word_data.hdr.arg[stepctl_motion_pkg::MS_W-1:0];

  always_ff @(posedge CLK) begin
    if (rst) begin
      collecting <= 1'b0;
      word_cnt   <= '0;
      dir        <= 1'b0;
      divisor    <= stepctl_motion_pkg::DIV_RESET;
      ms_mode    <= stepctl_motion_pkg::MS_FULL;
      move_start <= 1'b0;
      reply_word <= '0;
      led        <= 1'b0;
    end else begin
      move_start <= 1'b0;
      if (word_valid) begin
        led <= ~led;  // Activity blink per word
        if (!collecting) begin
          case (word_data.hdr.code)
            stepctl_cmd_pkg::CMD_MOVE: begin
              collecting <= 1'b1;
              word_cnt   <= '0;
              dir        <= word_data.hdr.arg[0];
              reply_word <= steps_done;  // Shown during first data word
            end
            stepctl_cmd_pkg::CMD_DIVISOR: begin
              divisor <= word_data.hdr.arg[stepctl_motion_pkg::DIV_W-1:0];
            end
            stepctl_cmd_pkg::CMD_MICROSTEP: begin
              // Only full and half step supported
              if (mode_arg == stepctl_motion_pkg::MS_FULL ||
                  mode_arg == stepctl_motion_pkg::MS_HALF) begin
                ms_mode <= mode_arg;
              end
            end
            default: ;  // Unknown code, no effect
          endcase
        end else begin
          word_cnt <= word_cnt + 1'b1;
          if (word_cnt == 2'd0) begin
            reply_word <= steps_done;  // Refresh with latest count
          end
          if (last_word) begin
            collecting <= 1'b0;
            move_start <= 1'b1;  // Settings complete next cycle
          end
        end
      end
    end
  end

  // Move settings by data word index
  always_ff @(posedge CLK) begin
    if (word_valid && collecting) begin
      case (word_cnt)
        2'd0:    duration  <= word_data.data;
        2'd1:    rate_init <= word_data.data;
        default: rate_step <= word_data.data;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/hbridge_phase.sv
`default_nettype none

module hbridge_phase (
  input  logic                                  CLK,
  input  logic                                  rst,
  input  logic                                  step_pulse,
  input  logic                                  dir,
  input  logic [stepctl_motion_pkg::MS_W-1:0]   ms_mode,
  output logic                                  phase_a1,
  output logic                                  phase_a2,
  output logic                                  phase_b1,
  output logic                                  phase_b2
);

  logic [2:0] phase_idx;   // Position in half-step table
  logic [2:0] phase_inc;   // Index move per step
  logic [2:0] phase_next;

  // Full step skips the odd entries
  assign phase_inc = (ms_mode == stepctl_motion_pkg::MS_HALF) ? 3'd1 : 3'd2;

  // Wraps modulo 8
  assign phase_next = dir ? (phase_idx + phase_inc) : (phase_idx - phase_inc);

  always_ff @(posedge CLK) begin
    if (rst) begin
      phase_idx <= 3'd0;
      {phase_a1, phase_a2, phase_b1, phase_b2} <= stepctl_motion_pkg::PHASE_TABLE[3'd0];
    end else if (step_pulse) begin
      phase_idx <= phase_next;
      // Pins follow index in same edge
      {phase_a1, phase_a2, phase_b1, phase_b2} <= stepctl_motion_pkg::PHASE_TABLE[phase_next];
    end
  end

endmodule

`default_nettype wire

// File: src/stepctl_top.sv
`default_nettype none

module stepctl_top (
  input  logic CLK,
  input  logic rst,
  input  logic SCK,
  input  logic CS,
  input  logic COPI,
  output logic CIPO,
  output logic led,
  output logic busy,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  logic                                        word_valid;
  stepctl_cmd_pkg::spi_word_u                  word_data;
  logic [stepctl_cmd_pkg::WORD_W-1:0]          reply_word;  // Count back to host
  logic                                        dir;
  logic [stepctl_motion_pkg::DIV_W-1:0]        divisor;
  logic [stepctl_motion_pkg::MS_W-1:0]         ms_mode;
  logic [stepctl_motion_pkg::ACC_W-1:0]        duration;
  logic signed [stepctl_motion_pkg::ACC_W-1:0] rate_init;
  logic signed [stepctl_motion_pkg::ACC_W-1:0] rate_step;
  logic                                        move_start;
  logic                                        step_pulse;
  logic [stepctl_motion_pkg::ACC_W-1:0]        steps_done;

  spi_word_rx u_spi (
    .CLK        (CLK),
    .rst        (rst),
    .SCK        (SCK),
    .CS         (CS),
    .COPI       (COPI),
    .reply_word (reply_word),
    .CIPO       (CIPO),
    .word_valid (word_valid),
    .word_data  (word_data)
  );

  cmd_decoder u_dec (
    .CLK        (CLK),
    .rst        (rst),
    .word_valid (word_valid),
    .word_data  (word_data),
    .steps_done (steps_done),
    .dir        (dir),
    .divisor    (divisor),
    .ms_mode    (ms_mode),
    .duration   (duration),
    .rate_init  (rate_init),
    .rate_step  (rate_step),
    .move_start (move_start),
    .reply_word (reply_word),
    .led        (led)
  );

  move_profile u_prof (
    .CLK        (CLK),
    .rst        (rst),
    .move_start (move_start),
    .divisor    (divisor),
    .duration   (duration),
    .rate_init  (rate_init),
    .rate_step  (rate_step),
    .step_pulse (step_pulse),
    .busy       (busy),
    .steps_done (steps_done)
  );

  // Single axis bridge
  hbridge_phase u_bridge (
    .CLK        (CLK),
    .rst        (rst),
    .step_pulse (step_pulse),
    .dir        (dir),
    .ms_mode    (ms_mode),
    .phase_a1   (phase_a1),
    .phase_a2   (phase_a2),
    .phase_b1   (phase_b1),
    .phase_b2   (phase_b2)
  );

endmodule

`default_nettype wire

// File: stepctl.f
common/stepctl_cmd_pkg.sv
common/stepctl_motion_pkg.sv
spi/spi_word_rx.sv
src/cmd_decoder.sv
motion/move_profile.sv
src/hbridge_phase.sv
src/stepctl_top.sv
tests/tb_stepctl.sv

// File: tests/tb_stepctl.sv
`default_nettype none

module tb_stepctl;

  localparam int N_RAND   = 10;                     // Random moves
  localparam int MAX_DUR  = 64;                     // Ticks per move, upper bound
  localparam int MAX_DIV  = 4;                      // Largest divisor used
  localparam int N_MOVES  = N_RAND + 4;
  localparam int N_WORDS  = 7 * N_MOVES;            // Move words plus setup headers
  localparam int WORD_CYC = 8 + 64 * 16 + 8 + 16;   // CS lead, bits, tail, gap
  localparam longint LIMIT = 2 * (longint'(N_MOVES) * MAX_DUR * MAX_DIV * 8
                                  + longint'(N_WORDS) * WORD_CYC * 8 + 10 * 8);

  logic CLK, rst, SCK, CS, COPI;
  logic CIPO, led, busy, phase_a1, phase_a2, phase_b1, phase_b2;

  integer      seed = 82296;
  logic        exp_led;
  logic        mdl_dir;              // Direction of the move in progress
  logic [2:0]  mdl_mode;             // Mode the DUT should hold
  logic [23:0] mdl_div;
  logic [2:0]  mdl_idx;              // Phase index at end of last move
  logic [63:0] last_count;           // Step count of previous move
  logic [3:0]  pins_q;
  logic [2:0]  step_idx;             // Index followed step by step
  int          phase_changes = 0;
  longint      busy_cycles = 0;

  stepctl_top DUT (
    .CLK(CLK), .rst(rst), .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO), .led(led),
    .busy(busy), .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Step rule: add rate, step at threshold, then ramp the rate
  function automatic longint expected_steps(input longint dur, input longint r0,
                                            input longint rs);
    longint acc;
    longint rate;
    longint cnt;
    acc  = 0;
    rate = r0;
    cnt  = 0;
    for (longint k = 0; k < dur; k++) begin
      acc = acc + rate;
      if (acc >= stepctl_motion_pkg::STEP_THRESHOLD) begin
        cnt = cnt + 1;                                // One step at most per tick
        acc = acc - stepctl_motion_pkg::STEP_THRESHOLD;
      end
      rate = rate + rs;
    end
    return cnt;
  endfunction

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge CLK);
    #1;                                               // Drive point after the edge
  endtask

  // One CS frame, SCK at CLK/16, reply bit read while SCK is low
  task automatic send_word(input logic [63:0] word, output logic [63:0] reply);
    wait_clocks(1);
    CS = 1'b0;
    wait_clocks(8);                                   // Reply loads on CS fall
    for (int i = 63; i >= 0; i--) begin
      COPI = word[i];
      wait_clocks(8);
      reply[i] = CIPO;
      SCK = 1'b1;                                     // DUT samples COPI here
      wait_clocks(8);
      SCK = 1'b0;
    end
    wait_clocks(8);
    CS = 1'b1;
    wait_clocks(16);                                  // Word strobe and decode
    exp_led = ~exp_led;
    check_value("led", 64'(led), 64'(exp_led));
  endtask

  task automatic send_cmd(input logic [7:0] code, input logic [55:0] arg);
    stepctl_cmd_pkg::spi_word_u w;
    logic [63:0] unused_reply;
    w.hdr.code = code;
    w.hdr.arg  = arg;
    send_word(w.data, unused_reply);
  endtask

  task automatic set_divisor(input logic [23:0] d);
    send_cmd(stepctl_cmd_pkg::CMD_DIVISOR, 56'(d));
    mdl_div = d;
  endtask

  task automatic set_mode(input logic [2:0] m);
    send_cmd(stepctl_cmd_pkg::CMD_MICROSTEP, 56'(m));
    if (m == stepctl_motion_pkg::MS_FULL || m == stepctl_motion_pkg::MS_HALF) begin
      mdl_mode = m;                                   // Other codes leave mode alone
    end
  endtask

  // Full move: header, three data words, wait for end, compare
  task automatic run_move(input logic dir, input longint dur, input longint r0,
                          input longint rs);
    logic [63:0] reply;
    int          changes0;
    longint      busy0;
    longint      exp_cnt;
    longint      idx_move;
    changes0 = phase_changes;
    busy0    = busy_cycles;
    mdl_dir  = dir;
    send_cmd(stepctl_cmd_pkg::CMD_MOVE, {55'd0, dir});
    send_word(dur, reply);
    check_value("reply", reply, last_count);          // Previous move's count
    send_word(r0, reply);
    send_word(rs, reply);
    while (busy === 1'b1) begin
      wait_clocks(1);
    end
    wait_clocks(4);
    exp_cnt  = expected_steps(dur, r0, rs);
    idx_move = exp_cnt * ((mdl_mode == stepctl_motion_pkg::MS_HALF) ? 1 : 2);
    if (!dir) idx_move = -idx_move;
    mdl_idx = mdl_idx + idx_move[2:0];                // Modulo 8
    check_value("step count", 64'(phase_changes - changes0), exp_cnt);
    check_value("busy cycles", busy_cycles - busy0, dur * longint'(mdl_div) + 1);
    check_value("phase pins", 64'({phase_a1, phase_a2, phase_b1, phase_b2}),
                64'(stepctl_motion_pkg::PHASE_TABLE[mdl_idx]));
    last_count = exp_cnt;
  endtask

  // Phase and busy monitor on the falling edge
  always @(negedge CLK) begin
    logic [3:0] pins;
    logic [2:0] inc;
    pins = {phase_a1, phase_a2, phase_b1, phase_b2};
    inc  = (mdl_mode == stepctl_motion_pkg::MS_HALF) ? 3'd1 : 3'd2;
    if (rst) begin
      pins_q   = pins;
      step_idx = 3'd0;
    end else if (pins != pins_q) begin
      phase_changes = phase_changes + 1;              // Each step moves the pins
      step_idx = mdl_dir ? step_idx + inc : step_idx - inc;
      check_value("phase pins per step", 64'(pins),
                  64'(stepctl_motion_pkg::PHASE_TABLE[step_idx]));
      pins_q = pins;
    end
    if (busy === 1'b1) busy_cycles = busy_cycles + 1;
  end

  initial begin
    #(LIMIT);
    $display("Watchdog expired before the test sequence finished");
    $display("test failed");
    $fatal(1, "timeout");
  end

  initial begin
    longint      r0;
    longint      rs;
    longint      dur;
    logic [23:0] div;
    rst = 1'b1;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    exp_led = 1'b0;
    mdl_dir = 1'b0;
    mdl_mode = stepctl_motion_pkg::MS_FULL;
    mdl_div = stepctl_motion_pkg::DIV_RESET;
    mdl_idx = 3'd0;
    last_count = '0;
    repeat (10) @(posedge CLK);
    #1 rst = 1'b0;
    wait_clocks(2);
    check_value("busy", 64'(busy), 64'(0));
    check_value("led", 64'(led), 64'(0));
    check_value("phase pins", 64'({phase_a1, phase_a2, phase_b1, phase_b2}),
                64'(stepctl_motion_pkg::PHASE_TABLE[0]));
    set_divisor(24'd3);
    set_mode(stepctl_motion_pkg::MS_FULL);
    run_move(1'b1, 40, 64'sd1 <<< 38, 0);             // Quarter step per tick
    set_mode(stepctl_motion_pkg::MS_HALF);
    run_move(1'b0, 50, 64'sd1 <<< 37, 64'sd1 <<< 34);  // Ramp up while moving down
    run_move(1'b1, 0, 64'sd1 <<< 40, 0);              // Empty move, reads back count
    for (int n = 0; n < N_RAND; n++) begin
      set_mode(($random(seed) & 1) ? stepctl_motion_pkg::MS_HALF
                                   : stepctl_motion_pkg::MS_FULL);
      div = 24'(1 + {$random(seed)} % MAX_DIV);
      set_divisor(div);
      dur = longint'({$random(seed)} % MAX_DUR);
      r0  = longint'($random(seed)) * 512 + (64'sd1 <<< 39);
      rs  = longint'($random(seed)) * 8;
      run_move(1'($random(seed)), dur, r0, rs);
    end
    // Bad codes must not disturb the held settings
    set_divisor(24'd2);                               // Differs from the bad args
    set_mode(stepctl_motion_pkg::MS_HALF);            // Mode 5 would act as full step
    send_cmd(8'h02, 56'h3);
    send_cmd(8'hff, 56'h0);
    set_mode(3'd5);
    run_move(1'b1, 30, 3 * (64'sd1 <<< 37), 64'sd1 <<< 33);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
